// File: logic/boot_rom.sv
// ----------------------------------------
// Boot ROM
// Registered word lookup into the boot image
// ----------------------------------------
`default_nettype none

module boot_rom
  import soc_pkg::*;
(
  input  logic                   clk,
  input  logic                   rd_en_i,
  input  logic [RomIdxWidth-1:0] word_idx_i,
  output logic [DataWidth-1:0]   rdata_o
);

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rdata_o <= BootImage[word_idx_i];  // Holds the last word between reads
    end
  end

endmodule

`default_nettype wire

// File: logic/clint_timer.sv
// ----------------------------------------
// Core-local timer
// rtc at half the clock rate drives mtime,
// compare against mtimecmp raises the irq
// ----------------------------------------
`default_nettype none

module clint_timer
  import soc_pkg::*;
(
  input  logic                 clk,
  input  logic                 sys_rstn_i,
  input  logic                 acc_en_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] offset_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic [StrbWidth-1:0] be_i,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 timer_irq_o
);

  logic                 rtc_q;
  logic                 rtc_d_q;
  logic                 rtc_rise;
  logic                 is_cmp;
  logic [DataWidth-1:0] mtime_q;
  logic [DataWidth-1:0] mtimecmp_q;

  assign rtc_rise = rtc_q & ~rtc_d_q;
  assign is_cmp   = (offset_i == MtimecmpOffset);  // Anything else decoded is mtime

  always_ff @(posedge clk or negedge sys_rstn_i) begin
    if (!sys_rstn_i) begin
      rtc_q       <= 1'b0;
      rtc_d_q     <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_o <= 1'b0;
    end else begin
      rtc_q   <= ~rtc_q;   // Divide by two
      rtc_d_q <= rtc_q;
      if (acc_en_i && we_i && !is_cmp) begin
        for (int i = 0; i < StrbWidth; i++) begin
          if (be_i[i]) mtime_q[8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (acc_en_i && we_i && is_cmp) begin
        for (int i = 0; i < StrbWidth; i++) begin
          if (be_i[i]) mtimecmp_q[8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
      timer_irq_o <= (mtime_q >= mtimecmp_q);
    end
  end

  // Read data
  always_ff @(posedge clk) begin
    if (acc_en_i && !we_i) begin
      rdata_o <= is_cmp ? mtimecmp_q : mtime_q;
    end
  end

endmodule

`default_nettype wire

// File: logic/periph_fabric.sv
// ----------------------------------------
// Peripheral fabric
// Decodes the address map, holds the GPIO
// registers and forms the registered response
// ----------------------------------------
`default_nettype none

module periph_fabric
  import soc_pkg::*;
(
  input  logic      clk,
  input  logic      sys_rstn_i,
  input  logic      issue_valid_i,
  input  bus_req_t  issue_req_i,
  input  logic [7:0] sw_i,
  output logic [7:0] led_o,
  output logic      timer_irq_o,
  output logic      fab_valid_o,
  output bus_resp_t fab_resp_o
);

  periph_sel_t          sel;
  periph_sel_t          sel_q;
  logic [AddrWidth-1:0] addr;
  logic [AddrWidth-1:0] rom_offset;
  logic [AddrWidth-1:0] clint_offset;
  logic                 in_rom;
  logic                 is_clint;
  logic                 is_gpio;
  logic                 is_led;
  logic                 acc_err;
  logic                 rom_en;
  logic                 clint_en;
  logic                 gpio_en;
  logic                 led_we;
  logic                 err_q;
  logic                 rd_q;            // Response carries read data
  logic [DataWidth-1:0] rom_rdata;
  logic [DataWidth-1:0] clint_rdata;
  logic [DataWidth-1:0] gpio_rdata_q;

  assign addr         = issue_req_i.addr;
  assign rom_offset   = addr - RomBase;
  assign clint_offset = addr - ClintBase;
  assign in_rom       = (addr >= RomBase) &&
                        (addr < RomBase + AddrWidth'(RomWords * StrbWidth)) &&
                        (addr[ByteOffWidth-1:0] == '0);
  assign is_clint     = (addr == ClintBase + MtimecmpOffset) ||
                        (addr == ClintBase + MtimeOffset);
  assign is_led       = (addr == GpioBase + LedOffset);
  assign is_gpio      = is_led || (addr == GpioBase + SwOffset);

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  always_comb begin
    sel = SEL_NONE;
    if (in_rom) begin
      sel = SEL_ROM;
    end else if (is_clint) begin
      sel = SEL_CLINT;
    end else if (is_gpio) begin
      sel = SEL_GPIO;
    end
  end

  // ROM writes and switch writes are refused like unmapped accesses
  assign acc_err  = (sel == SEL_NONE) ||
                    (sel == SEL_ROM && issue_req_i.we) ||
                    (sel == SEL_GPIO && issue_req_i.we && !is_led);
  assign rom_en   = issue_valid_i && in_rom && !issue_req_i.we;
  assign clint_en = issue_valid_i && is_clint;
  assign gpio_en  = issue_valid_i && is_gpio && !acc_err;
  assign led_we   = gpio_en && issue_req_i.we && issue_req_i.be[0];

  boot_rom boot_rom_inst (
    .clk        ( clk                                     ),
    .rd_en_i    ( rom_en                                  ),
    .word_idx_i ( rom_offset[ByteOffWidth +: RomIdxWidth] ),
    .rdata_o    ( rom_rdata                               )
  );

  clint_timer clint_timer_inst (
    .clk         ( clk               ),
    .sys_rstn_i  ( sys_rstn_i        ),
    .acc_en_i    ( clint_en          ),
    .we_i        ( issue_req_i.we    ),
    .offset_i    ( clint_offset      ),
    .wdata_i     ( issue_req_i.wdata ),
    .be_i        ( issue_req_i.be    ),
    .rdata_o     ( clint_rdata       ),
    .timer_irq_o ( timer_irq_o       )
  );

  // ----------------------------------------
  // GPIO registers and response stage
  // ----------------------------------------
  always_ff @(posedge clk or negedge sys_rstn_i) begin
    if (!sys_rstn_i) begin
      led_o       <= '0;
      fab_valid_o <= 1'b0;
      err_q       <= 1'b0;
      rd_q        <= 1'b0;
      sel_q       <= SEL_NONE;
    end else begin
      if (led_we) led_o <= issue_req_i.wdata[7:0];
      fab_valid_o <= issue_valid_i;
      if (issue_valid_i) begin
        err_q <= acc_err;
        rd_q  <= !acc_err && !issue_req_i.we;
        sel_q <= sel;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (gpio_en && !issue_req_i.we) begin
      gpio_rdata_q <= {{(DataWidth-8){1'b0}}, (is_led ? led_o : sw_i)};
    end
  end

  always_comb begin
    fab_resp_o.err   = err_q;
    fab_resp_o.rdata = '0;   // Writes and errors return zero
    if (rd_q) begin
      case (sel_q)
        SEL_ROM:   fab_resp_o.rdata = rom_rdata;
        SEL_CLINT: fab_resp_o.rdata = clint_rdata;
        SEL_GPIO:  fab_resp_o.rdata = gpio_rdata_q;
        default:   fab_resp_o.rdata = '0;
      endcase
    end
  end

  // Region hits must not overlap
  a_enables_onehot0: assert property (
    @(posedge clk) disable iff (!sys_rstn_i) $onehot0({rom_en, clint_en, gpio_en})
  );

endmodule

`default_nettype wire

// File: logic/req_ingress.sv
// ----------------------------------------
// Request ingress
// Buffers incoming requests in a small FIFO
// and returns credits to the upstream side
// ----------------------------------------
`default_nettype none

module req_ingress
  import soc_pkg::*;
(
  input  logic     clk,
  input  logic     sys_rstn_i,
  input  bus_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_credit_o,
  input  logic     can_issue_i,
  output logic     issue_valid_o,
  output bus_req_t issue_req_o
);

  bus_req_t               mem_q [ReqFifoDepth];
  logic [ReqPtrWidth-1:0] wr_ptr_q;
  logic [ReqPtrWidth-1:0] rd_ptr_q;
  logic [ReqCntWidth-1:0] count_q;
  logic [ReqCntWidth-1:0] grant_q;     // Initial credits still to hand out
  logic                   fifo_empty;
  logic                   fifo_full;
  logic                   pop;

  assign fifo_empty = (count_q == '0);
  assign fifo_full  = (count_q == ReqCntWidth'(ReqFifoDepth));
  assign pop        = !fifo_empty && can_issue_i;

  assign issue_valid_o = pop;
  assign issue_req_o   = mem_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (req_valid_i) mem_q[wr_ptr_q] <= req_i;
  end

  always_ff @(posedge clk or negedge sys_rstn_i) begin
    if (!sys_rstn_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      grant_q      <= ReqCntWidth'(ReqFifoDepth);
      req_credit_o <= 1'b0;
    end else begin
      if (req_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)         rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + ReqCntWidth'(req_valid_i) - ReqCntWidth'(pop);
      // A pop takes the pulse slot, the initial grant waits a cycle
      if (!pop && grant_q != '0) grant_q <= grant_q - 1'b1;
      req_credit_o <= pop || (grant_q != '0);
    end
  end

  // Upstream only sends while it holds a credit
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!sys_rstn_i) req_valid_i |-> !fifo_full
  );

endmodule

`default_nettype wire

// File: logic/reset_sequencer.sv
// ----------------------------------------
// Power-on reset sequencer
// Holds the system reset until the counter
// saturates and the PLL reports lock
// ----------------------------------------
`default_nettype none

module reset_sequencer
  import soc_pkg::*;
(
  input  logic clk,
  input  logic cpu_resetn,
  input  logic pll_locked_i,
  output logic sys_rstn_o
);

  logic [ResetCountWidth-1:0] count_q;
  logic                       count_done;

  assign count_done = &count_q;

  always_ff @(posedge clk or negedge cpu_resetn) begin
    if (!cpu_resetn) begin
      count_q    <= '0;
      sys_rstn_o <= 1'b0;
    end else begin
      if (!count_done) count_q <= count_q + 1'b1;  // Saturate at all ones
      // Once released, stays released until the next board reset
      sys_rstn_o <= sys_rstn_o | (count_done & pll_locked_i);
    end
  end

endmodule

`default_nettype wire

// File: logic/resp_egress.sv
// ----------------------------------------
// Response egress
// Registers responses onto the output and
// tracks downstream buffer credits
// ----------------------------------------
`default_nettype none

module resp_egress
  import soc_pkg::*;
(
  input  logic      clk,
  input  logic      sys_rstn_i,
  input  logic      issue_valid_i,
  input  logic      fab_valid_i,
  input  bus_resp_t fab_resp_i,
  input  logic      resp_credit_i,
  output logic      can_issue_o,
  output bus_resp_t resp_o,
  output logic      resp_valid_o
);

  logic [RespCntWidth-1:0] credit_q;

  // A slot is reserved at issue time, so in-flight items always fit
  assign can_issue_o = (credit_q != '0);

  always_ff @(posedge clk or negedge sys_rstn_i) begin
    if (!sys_rstn_i) begin
      credit_q     <= RespCntWidth'(RespCredits);
      resp_valid_o <= 1'b0;
    end else begin
      if (issue_valid_i && !resp_credit_i) begin
        credit_q <= credit_q - 1'b1;
      end else if (!issue_valid_i && resp_credit_i) begin
        credit_q <= credit_q + 1'b1;
      end
      resp_valid_o <= fab_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fab_valid_i) resp_o <= fab_resp_i;
  end

  // Downstream never returns more slots than it has
  a_credit_bound: assert property (
    @(posedge clk) disable iff (!sys_rstn_i) credit_q <= RespCntWidth'(RespCredits)
  );

endmodule

`default_nettype wire

// File: logic/soc_pkg.sv
// ----------------------------------------
// SoC peripheral package
// Bus widths, address map, credit sizes,
// boot image and the shared bus types
// ----------------------------------------
`default_nettype none

package soc_pkg;

  // Bus geometry
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 64;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);

  // Flow control
  localparam int unsigned ReqFifoDepth = 4;   // Also the upstream credit total
  localparam int unsigned ReqPtrWidth  = $clog2(ReqFifoDepth);
  localparam int unsigned ReqCntWidth  = $clog2(ReqFifoDepth + 1);
  localparam int unsigned RespCredits  = 2;   // Downstream response slots
  localparam int unsigned RespCntWidth = $clog2(RespCredits + 1);

  localparam int unsigned ResetCountWidth = 6;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam logic [AddrWidth-1:0] RomBase        = 32'h0001_0000;
  localparam int unsigned          RomWords       = 8;
  localparam int unsigned          RomIdxWidth    = $clog2(RomWords);
  localparam logic [AddrWidth-1:0] ClintBase      = 32'h0200_0000;
  localparam logic [AddrWidth-1:0] MtimecmpOffset = 32'h0000_4000;
  localparam logic [AddrWidth-1:0] MtimeOffset    = 32'h0000_BFF8;
  localparam logic [AddrWidth-1:0] GpioBase       = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] LedOffset      = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] SwOffset       = 32'h0000_0008;

  // First-stage loader, two instructions per word
  localparam logic [DataWidth-1:0] BootImage [RomWords] = '{
    64'h0000_0297_0202_8293,
    64'h0002_8067_0000_0013,
    64'hF140_2573_0000_0597,
    64'h0185_8593_1050_0073,
    64'h4000_02B7_0FF0_0313,
    64'h0062_B023_0000_006F,
    64'h0000_0000_8000_0000,
    64'hDEAD_BEEF_0BAD_F00D
  };

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] be;
    logic                 we;
  } bus_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_resp_t;

  typedef enum logic [1:0] {
    SEL_ROM,
    SEL_CLINT,
    SEL_GPIO,
    SEL_NONE
  } periph_sel_t;

endpackage

`default_nettype wire

// File: logic/soc_top.sv
// ----------------------------------------
// SoC peripheral top level
// Reset sequencing, request ingress, the
// peripheral fabric and response egress
// ----------------------------------------
`default_nettype none

module soc_top
  import soc_pkg::*;
(
  input  logic       clk,
  input  logic       cpu_resetn,
  input  logic       pll_locked_i,
  input  bus_req_t   req_i,
  input  logic       req_valid_i,
  output logic       req_credit_o,
  output bus_resp_t  resp_o,
  output logic       resp_valid_o,
  input  logic       resp_credit_i,
  input  logic [7:0] sw_i,
  output logic [7:0] led_o,
  output logic       timer_irq_o
);

  logic      sys_rstn;
  logic      can_issue;
  logic      issue_valid;
  bus_req_t  issue_req;
  logic      fab_valid;
  bus_resp_t fab_resp;

  reset_sequencer reset_sequencer_inst (
    .clk          ( clk          ),
    .cpu_resetn   ( cpu_resetn   ),
    .pll_locked_i ( pll_locked_i ),
    .sys_rstn_o   ( sys_rstn     )
  );

  req_ingress req_ingress_inst (
    .clk           ( clk          ),
    .sys_rstn_i    ( sys_rstn     ),
    .req_i         ( req_i        ),
    .req_valid_i   ( req_valid_i  ),
    .req_credit_o  ( req_credit_o ),
    .can_issue_i   ( can_issue    ),
    .issue_valid_o ( issue_valid  ),
    .issue_req_o   ( issue_req    )
  );

  periph_fabric periph_fabric_inst (
    .clk           ( clk         ),
    .sys_rstn_i    ( sys_rstn    ),
    .issue_valid_i ( issue_valid ),
    .issue_req_i   ( issue_req   ),
    .sw_i          ( sw_i        ),
    .led_o         ( led_o       ),
    .timer_irq_o   ( timer_irq_o ),
    .fab_valid_o   ( fab_valid   ),
    .fab_resp_o    ( fab_resp    )
  );

  resp_egress resp_egress_inst (
    .clk           ( clk           ),
    .sys_rstn_i    ( sys_rstn      ),
    .issue_valid_i ( issue_valid   ),
    .fab_valid_i   ( fab_valid     ),
    .fab_resp_i    ( fab_resp      ),
    .resp_credit_i ( resp_credit_i ),
    .can_issue_o   ( can_issue     ),
    .resp_o        ( resp_o        ),
    .resp_valid_o  ( resp_valid_o  )
  );

endmodule

`default_nettype wire

// File: project.f
logic/soc_pkg.sv
logic/reset_sequencer.sv
logic/req_ingress.sv
logic/boot_rom.sv
logic/clint_timer.sv
logic/periph_fabric.sv
logic/resp_egress.sv
logic/soc_top.sv
tb/tb_soc_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_soc_top -f project.f -o tb_soc_top_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: tb/soc_stim.txt
# R addr rdata err | W addr wdata be err | S switches | I irq | B count (next count lines)
# mtime reads at 0200BFF8 carry 0 as rdata and are only checked to never decrease
I 0
R 00010000 0000029702028293 0
R 00010008 0002806700000013 0
W 40000000 00000000000000A5 01 0
R 40000000 00000000000000A5 0
S 3C
R 40000008 000000000000003C 0
W 02004000 0000000000000000 FF 0
I 1
W 02004000 FFFFFFFFFFFFFFFF FF 0
I 0
R 0200BFF8 0000000000000000 0
R 0200BFF8 0000000000000000 0
R 30000000 0000000000000000 1
W 00010000 0000000000001234 FF 1
W 40000008 0000000000000055 01 1
R 40000000 00000000000000A5 0
B 6
R 00010010 F140257300000597 0
R 00010018 0185859310500073 0
R 00010020 400002B70FF00313 0
R 00010028 0062B0230000006F 0
R 00010030 0000000080000000 0
R 00010038 DEADBEEF0BADF00D 0

// File: tb/tb_soc_top.sv
// ----------------------------------------
// Testbench for the SoC peripheral top
// Replays the stimulus file, models both
// credit loops and scores every response
// ----------------------------------------
`default_nettype none

module tb_soc_top
  import soc_pkg::*;
();

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
    logic                 is_mtime;  // Data only has to be non-decreasing
  } expect_t;

  logic       clk;
  logic       cpu_resetn;
  logic       pll_locked;
  bus_req_t   req;
  logic       req_valid;
  logic       req_credit;
  bus_resp_t  resp;
  logic       resp_valid;
  logic       resp_credit;
  logic [7:0] sw;
  logic [7:0] led;
  logic       timer_irq;

  expect_t              exp_q [$];
  int unsigned          up_credits   = 0;   // Credits held by the upstream model
  int unsigned          owed_credits = 0;   // Downstream slots not yet returned
  logic                 hold_credits = 1'b0;
  int unsigned          n_resp       = 0;
  logic [DataWidth-1:0] last_mtime   = '0;
  logic [7:0]           led_model    = '0;

  soc_top soc_top_inst (
    .clk           ( clk         ),
    .cpu_resetn    ( cpu_resetn  ),
    .pll_locked_i  ( pll_locked  ),
    .req_i         ( req         ),
    .req_valid_i   ( req_valid   ),
    .req_credit_o  ( req_credit  ),
    .resp_o        ( resp        ),
    .resp_valid_o  ( resp_valid  ),
    .resp_credit_i ( resp_credit ),
    .sw_i          ( sw          ),
    .led_o         ( led         ),
    .timer_irq_o   ( timer_irq   )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s (got 0x%h, expected 0x%h)",
               $time, what, actual, expected);
      $display("test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // ----------------------------------------
  // Bus helpers
  // ----------------------------------------
  task automatic step_cycle();
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic send_req(input logic [31:0] addr, input logic [63:0] wdata,
                          input logic [7:0] be, input logic we,
                          input logic [63:0] exp_rdata, input logic exp_err);
    expect_t entry;
    step_cycle();
    while (up_credits == 0) step_cycle();  // Never send without a credit
    req.addr  = addr;
    req.wdata = wdata;
    req.be    = be;
    req.we    = we;
    req_valid = 1'b1;
    up_credits--;
    entry.rdata    = exp_rdata;
    entry.err      = exp_err;
    entry.is_mtime = !we && (addr == ClintBase + MtimeOffset);
    exp_q.push_back(entry);
  endtask

  task automatic wait_drain();
    step_cycle();
    while (exp_q.size() != 0 || owed_credits != 0) @(negedge clk);
  endtask

  // Burst is queued, only the reserved slots may have come out
  task automatic release_burst(input int unsigned count, input int unsigned resp_base);
    repeat (16) step_cycle();
    check_value(64'(n_resp - resp_base), 64'(count < RespCredits ? count : RespCredits),
                "responses while downstream credits are held");
    hold_credits = 1'b0;
    wait_drain();
  endtask

  // ----------------------------------------
  // Credit counting and scoreboard
  // ----------------------------------------
  initial begin : response_monitor
    expect_t entry;
    forever begin
      @(negedge clk);
      if (req_credit) begin
        up_credits++;
        check_value(64'(up_credits <= ReqFifoDepth), 64'd1, "upstream credits above depth");
      end
      if (resp_valid) begin
        if (exp_q.size() == 0) begin
          $display("A response arrived at time %0t with no request outstanding", $time);
          $display("test failed");
          $fatal(1, "unexpected response");
        end
        entry = exp_q.pop_front();
        if (entry.is_mtime) begin
          check_value(64'(resp.rdata >= last_mtime), 64'd1, "mtime went backwards");
          last_mtime = resp.rdata;
        end else begin
          check_value(resp.rdata, entry.rdata, "read data");
        end
        check_value(64'(resp.err), 64'(entry.err), "error flag");
        n_resp++;
        owed_credits++;
        check_value(64'(owed_credits <= RespCredits), 64'd1, "responses beyond free slots");
      end
    end
  end

  // Downstream frees its slots after a random gap
  initial begin : credit_return
    int unsigned seed_init;
    int unsigned gap;
    seed_init = $urandom(32'h70ace775);
    gap = 0;
    forever begin
      @(posedge clk);
      #1;
      resp_credit = 1'b0;
      if (owed_credits > 0 && !hold_credits) begin
        if (gap > 0) begin
          gap--;
        end else begin
          resp_credit = 1'b1;
          owed_credits--;
          gap = $urandom_range(3, 0);
        end
      end
    end
  end

  initial begin : watchdog
    int                 fd;
    int unsigned        n_lines;
    logic [8*160-1:0]   line_buf;
    n_lines = 0;
    fd = $fopen("tb/soc_stim.txt", "r");
    if (fd != 0) begin
      while ($fgets(line_buf, fd) != 0) n_lines++;
      $fclose(fd);
    end
    repeat ((n_lines + 1) * 200) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", (n_lines + 1) * 200);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : stimulus
    int               fd;
    int               code;
    logic [7:0]       tok;
    logic [8*160-1:0] skip_buf;
    logic [31:0]      addr;
    logic [63:0]      data;
    logic [63:0]      exp_rdata;
    logic [7:0]       be;
    logic [7:0]       exp_err;
    logic [7:0]       val;
    int unsigned      burst_left;
    int unsigned      burst_count;
    int unsigned      resp_base;
    cpu_resetn  = 1'b0;
    pll_locked  = 1'b1;
    req         = '0;
    req_valid   = 1'b0;
    resp_credit = 1'b0;
    sw          = '0;
    burst_left  = 0;
    burst_count = 0;
    resp_base   = 0;
    repeat (3) @(posedge clk);
    #1 cpu_resetn = 1'b1;
    // System reset release is followed by the initial credit grant
    while (up_credits != ReqFifoDepth) @(negedge clk);
    fd = $fopen("tb/soc_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tb/soc_stim.txt");
      $display("test failed");
      $fatal(1, "no stimulus");
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      case (tok)
        "#": code = $fgets(skip_buf, fd);
        "R", "W": begin
          if (tok == "R") begin
            code = $fscanf(fd, "%h %h %h", addr, exp_rdata, exp_err);
            send_req(addr, '0, '0, 1'b0, exp_rdata, exp_err[0]);
          end else begin
            code = $fscanf(fd, "%h %h %h %h", addr, data, be, exp_err);
            send_req(addr, data, be, 1'b1, '0, exp_err[0]);
            // Only a clean write with byte 0 enabled lands in the LED register
            if (addr == GpioBase + LedOffset && exp_err[0] == 1'b0 && be[0]) begin
              led_model = data[7:0];
            end
          end
          if (burst_left > 0) begin
            burst_left--;
            if (burst_left == 0) release_burst(burst_count, resp_base);
          end else begin
            wait_drain();
            check_value(64'(led), 64'(led_model), "LED register");
          end
        end
        "S": begin
          code = $fscanf(fd, "%h", val);
          step_cycle();
          sw = val;
        end
        "I": begin
          code = $fscanf(fd, "%h", val);
          check_value(64'(timer_irq), 64'(val[0]), "timer interrupt");
        end
        "B": begin
          code = $fscanf(fd, "%d", burst_left);
          wait_drain();
          step_cycle();
          hold_credits = 1'b1;
          burst_count  = burst_left;
          resp_base    = n_resp;
        end
        default: begin
          $display("Unknown command in the stimulus file: %s", tok);
          $display("test failed");
          $fatal(1, "bad stimulus");
        end
      endcase
    end
    $fclose(fd);
    wait_drain();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
